//--- fram_wr_top.f
+incdir+logic
logic/video_pkg.sv
logic/axi_pkg.sv
logic/pixel_packer.sv
logic/beat_fifo.sv
logic/burst_writer.sv
logic/fram_wr_top.sv
verification/axi_mem_model.sv
verification/fram_wr_tb.sv

//--- logic/axi_pkg.sv
`include "fram_params.svh"

package axi_pkg;

    ////////////////////////////////////////
    // axi write channel encodings
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,      // only type issued here
        WRAP  = 2'b10
    } burst_e;

    // write address channel
    typedef struct packed {
        logic [`FRAM_ADDR_WIDTH-1:0] addr;
        logic [3:0]                  len;    // beats minus one
        logic [2:0]                  size;   // log2 bytes per beat
        burst_e                      burst;
        logic                        valid;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic [`FRAM_DQ_WIDTH*8-1:0] data;
        logic [`FRAM_DQ_WIDTH-1:0]   strb;   // one bit per byte lane
        logic                        last;
        logic                        valid;
    } axi_w_t;

    ////////////////////////////////////////
    // burst writer fsm
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        IDLE,       // waiting for a full line in the fifo
        ADDR,       // aw valid, waiting for awready
        DATA        // streaming the line
    } wr_state_e;

endpackage

//--- logic/beat_fifo.sv
`timescale 1ns/1ns
`include "fram_params.svh"

module beat_fifo
(
    input  logic                                ddr_clk,
    input  logic                                arst_n,
    input  logic                                beat_valid,     // push
    input  video_pkg::beat_t                    beat,
    input  logic                                pop,            // writer took head
    output video_pkg::beat_t                    head,           // oldest beat
    output logic [$clog2(`FRAM_FIFO_DEPTH):0]   level,          // beats held
    output logic                                credit_return   // one per pop
);
    import video_pkg::*;

    localparam int PTR_W = $clog2(`FRAM_FIFO_DEPTH);

    beat_t              mem [`FRAM_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;         // wraps at depth
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    always_ff @(posedge ddr_clk)
    begin
        if (beat_valid)
            mem[wr_ptr] <= beat;
    end

    assign head  = mem[rd_ptr];         // read is combinational
    assign level = count;

    ////////////////////////////////////////
    // pointers and fill count
    ////////////////////////////////////////
    always_ff @(posedge ddr_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (beat_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({beat_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // idle or push+pop
            endcase
        end
    end

    // slot freed, tell the packer next clock
    always_ff @(posedge ddr_clk or negedge arst_n)
    begin
        if (!arst_n)
            credit_return <= 1'b0;
        else
            credit_return <= pop;
    end

    // packer credits must keep us from filling past depth
    a_no_push_full: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        beat_valid |-> count != (PTR_W + 1)'(`FRAM_FIFO_DEPTH));

    // writer only pops what it waited for
    a_no_pop_empty: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        pop |-> count != '0);

endmodule

//--- logic/burst_writer.sv
`timescale 1ns/1ns
`include "fram_params.svh"

module burst_writer
(
    input  logic                                ddr_clk,
    input  logic                                arst_n,
    input  logic                                fsync,          // realigns line count
    input  video_pkg::beat_t                    head,           // fifo head beat
    input  logic [$clog2(`FRAM_FIFO_DEPTH):0]   level,          // fifo fill
    output logic                                pop,
    output axi_pkg::axi_aw_t                    aw,
    input  logic                                awready,
    output axi_pkg::axi_w_t                     w,
    input  logic                                wready,
    output logic                                frame_done,     // one clock pulse
    output logic [$clog2(`FRAM_SLOT_COUNT)-1:0] frame_slot,     // slot being written
    output logic                                init_done       // sticky
);
    import axi_pkg::*;

    localparam int BEAT_W     = $clog2(`FRAM_BURST_LEN);
    localparam int LINE_W     = $clog2(`FRAM_V_NUM);
    localparam int SLOT_W     = $clog2(`FRAM_SLOT_COUNT);
    localparam int LVL_W      = $clog2(`FRAM_FIFO_DEPTH) + 1;
    localparam int LINE_AW    = `FRAM_LINE_ADDR_WIDTH;
    localparam int PAD_W      = `FRAM_ADDR_WIDTH - LINE_AW - SLOT_W;
    localparam int LINE_BYTES = `FRAM_H_NUM * `FRAM_PIX_WIDTH / 8;

    wr_state_e                      state;
    logic [BEAT_W-1:0]              beat_cnt;   // beat within burst
    logic [LINE_W-1:0]              line_cnt;   // line within frame
    logic [`FRAM_ADDR_WIDTH-1:0]    addr_q;     // latched burst address
    logic [LINE_AW-1:0]             line_off;
    logic                           w_hs;
    logic                           last_beat;
    logic                           last_line;

    ////////////////////////////////////////
    // channel outputs
    ////////////////////////////////////////
    always_comb
    begin
        aw.addr  = addr_q;
        aw.len   = 4'(`FRAM_BURST_LEN - 1);
        aw.size  = 3'($clog2(`FRAM_DQ_WIDTH));     // 16 bytes per beat
        aw.burst = INCR;
        aw.valid = (state == ADDR);
    end

    always_comb
    begin
        w.data  = head;                 // fifo head holds until popped
        w.strb  = '1;                   // full beats only
        w.last  = last_beat;
        w.valid = (state == DATA);
    end

    assign w_hs      = w.valid && wready;
    assign pop       = w_hs;            // one beat per handshake
    assign last_beat = (beat_cnt == BEAT_W'(`FRAM_BURST_LEN - 1));
    assign last_line = (line_cnt == LINE_W'(`FRAM_V_NUM - 1));
    assign line_off  = LINE_AW'(line_cnt) * LINE_AW'(LINE_BYTES);

    // slot above the in-slot offset, upper bits zero
    always_ff @(posedge ddr_clk)
    begin
        if (state == IDLE)
            addr_q <= {{PAD_W{1'b0}}, frame_slot, line_off};
    end

    ////////////////////////////////////////
    // burst fsm
    ////////////////////////////////////////
    always_ff @(posedge ddr_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (level >= LVL_W'(`FRAM_BURST_LEN))
                        state <= ADDR;          // whole line buffered
                end
                ADDR:
                begin
                    if (awready)
                    begin
                        state    <= DATA;
                        beat_cnt <= '0;
                    end
                end
                DATA:
                begin
                    if (w_hs)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat)
                            state <= IDLE;      // line written
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // line, slot and init tracking
    ////////////////////////////////////////
    always_ff @(posedge ddr_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            line_cnt   <= '0;
            frame_slot <= '0;
            frame_done <= 1'b0;
            init_done  <= 1'b0;
        end
        else
        begin
            frame_done <= w_hs && last_beat && last_line;
            init_done  <= init_done | frame_done;   // first frame landed
            if (w_hs && last_beat)
            begin
                if (last_line)
                begin
                    line_cnt   <= '0;
                    frame_slot <= frame_slot + 1'b1;  // wraps over slots
                end
                else
                    line_cnt <= line_cnt + 1'b1;
            end
            else if (fsync)
                line_cnt <= '0;                     // frame start
        end
    end

    // payload holds while the slave stalls
    a_aw_stable: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        aw.valid && !awready |=> $stable(aw));

    a_w_stable: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        w.valid && !wready |=> $stable(w));

endmodule

//--- logic/fram_params.svh
`ifndef FRAM_PARAMS_SVH
`define FRAM_PARAMS_SVH

////////////////////////////////////////
// frame geometry
////////////////////////////////////////
`define FRAM_H_NUM              64      // pixels per line
`define FRAM_V_NUM              4       // lines per frame

////////////////////////////////////////
// memory side
////////////////////////////////////////
`define FRAM_DQ_WIDTH           16      // ddr data pins, beat is 8x this
`define FRAM_PIX_WIDTH          16      // stored rgb565 pixel
`define FRAM_PIX_PER_BEAT       ((`FRAM_DQ_WIDTH * 8) / `FRAM_PIX_WIDTH)
`define FRAM_BURST_LEN          (`FRAM_H_NUM / `FRAM_PIX_PER_BEAT)  // beats per line

// beat fifo holds two line bursts
`define FRAM_FIFO_DEPTH         16

////////////////////////////////////////
// address map
////////////////////////////////////////
`define FRAM_ADDR_WIDTH         28      // byte address into ddr
`define FRAM_LINE_ADDR_WIDTH    20      // offset bits inside one slot
`define FRAM_SLOT_COUNT         4       // frames rotate through these

`endif

//--- logic/fram_wr_top.sv
`timescale 1ns/1ns
`include "fram_params.svh"

module fram_wr_top
(
    input  logic                                ddr_clk,
    input  logic                                arst_n,
    input  video_pkg::pix_in_t                  pix_in,         // video source
    output axi_pkg::axi_aw_t                    aw,             // axi write address
    input  logic                                awready,
    output axi_pkg::axi_w_t                     w,              // axi write data
    input  logic                                wready,
    output logic                                frame_done,
    output logic [$clog2(`FRAM_SLOT_COUNT)-1:0] frame_slot,
    output logic                                init_done,
    output logic                                overflow
);
    import video_pkg::*;

    ////////////////////////////////////////
    // pipeline links
    ////////////////////////////////////////
    logic                                   beat_valid;     // packer to fifo
    beat_t                                  beat;
    logic                                   credit_return;  // fifo to packer
    beat_t                                  head;           // fifo to writer
    logic [$clog2(`FRAM_FIFO_DEPTH):0]      level;
    logic                                   pop;            // writer to fifo

    // stage 1, pack pixels into beats
    pixel_packer pixel_packer_i
    (
        .ddr_clk        (ddr_clk),
        .arst_n         (arst_n),
        .pix_in         (pix_in),
        .credit_return  (credit_return),
        .beat_valid     (beat_valid),
        .beat           (beat),
        .overflow       (overflow)
    );

    // stage 2, two lines of slack
    beat_fifo beat_fifo_i
    (
        .ddr_clk        (ddr_clk),
        .arst_n         (arst_n),
        .beat_valid     (beat_valid),
        .beat           (beat),
        .pop            (pop),
        .head           (head),
        .level          (level),
        .credit_return  (credit_return)
    );

    // stage 3, one axi burst per line
    burst_writer burst_writer_i
    (
        .ddr_clk        (ddr_clk),
        .arst_n         (arst_n),
        .fsync          (pix_in.fsync),
        .head           (head),
        .level          (level),
        .pop            (pop),
        .aw             (aw),
        .awready        (awready),
        .w              (w),
        .wready         (wready),
        .frame_done     (frame_done),
        .frame_slot     (frame_slot),
        .init_done      (init_done)
    );

endmodule

//--- logic/pixel_packer.sv
`timescale 1ns/1ns
`include "fram_params.svh"

module pixel_packer
(
    input  logic                ddr_clk,
    input  logic                arst_n,
    input  video_pkg::pix_in_t  pix_in,         // fsync, en, rgb888
    input  logic                credit_return,  // fifo freed one slot
    output logic                beat_valid,     // push into beat fifo
    output video_pkg::beat_t    beat,
    output logic                overflow        // sticky, a beat was lost
);
    import video_pkg::*;

    localparam int COL_W    = $clog2(`FRAM_H_NUM);
    localparam int LINE_W   = $clog2(`FRAM_V_NUM);
    localparam int SLOT_W   = $clog2(`FRAM_PIX_PER_BEAT);
    localparam int CREDIT_W = $clog2(`FRAM_FIFO_DEPTH) + 1;

    pack_state_e            state;
    logic [COL_W-1:0]       col_cnt;        // column within line
    logic [LINE_W-1:0]      line_cnt;       // line within frame
    logic [CREDIT_W-1:0]    credit_cnt;     // free fifo slots seen from here
    rgb565_t                pix565;
    logic                   take;           // pixel accepted this clock
    logic                   beat_full;      // pixel closes a beat
    logic                   send;           // closed beat has a credit

    ////////////////////////////////////////
    // intake and colour reduction
    ////////////////////////////////////////
    always_comb
    begin
        pix565.red   = pix_in.data.red[7:3];        // keep msbs
        pix565.green = pix_in.data.green[7:2];
        pix565.blue  = pix_in.data.blue[7:3];
    end

    assign take      = (state == ACTIVE) && pix_in.en && !pix_in.fsync;
    assign beat_full = take && (col_cnt[SLOT_W-1:0] == '1);   // 8th pixel of beat
    assign send      = beat_full && (credit_cnt != '0);

    always_ff @(posedge ddr_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= WAIT_SYNC;
            col_cnt  <= '0;
            line_cnt <= '0;
        end
        else if (pix_in.fsync)
        begin
            state    <= ACTIVE;                     // frame start
            col_cnt  <= '0;
            line_cnt <= '0;
        end
        else if (take)
        begin
            if (col_cnt == COL_W'(`FRAM_H_NUM - 1))
            begin
                col_cnt <= '0;                      // end of line
                if (line_cnt == LINE_W'(`FRAM_V_NUM - 1))
                begin
                    line_cnt <= '0;
                    state    <= WAIT_SYNC;          // frame done, wait next sync
                end
                else
                    line_cnt <= line_cnt + 1'b1;
            end
            else
                col_cnt <= col_cnt + 1'b1;
        end
    end

    // newest pixel enters at the top, so pixel 0 ends lowest
    always_ff @(posedge ddr_clk)
    begin
        if (take)
            beat <= {pix565, beat[`FRAM_PIX_PER_BEAT-1:1]};
    end

    ////////////////////////////////////////
    // credits and overflow
    ////////////////////////////////////////
    always_ff @(posedge ddr_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            beat_valid <= 1'b0;
            overflow   <= 1'b0;
            credit_cnt <= CREDIT_W'(`FRAM_FIFO_DEPTH);   // fifo empty
        end
        else
        begin
            beat_valid <= send;                     // one clock pulse
            if (beat_full && !send)
                overflow <= 1'b1;                   // no room, beat dropped
            case ({send, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;  // none or both
            endcase
        end
    end

    // a beat only leaves with a credit in hand
    a_send_needs_credit: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        beat_valid |-> $past(credit_cnt) != '0);

    // fifo never returns more than was sent
    a_credit_bound: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        credit_cnt <= CREDIT_W'(`FRAM_FIFO_DEPTH));

endmodule

//--- logic/video_pkg.sv
`include "fram_params.svh"

package video_pkg;

    ////////////////////////////////////////
    // pixel formats
    ////////////////////////////////////////

    // sensor side, 8 bits per colour
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    // stored format
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // one memory beat, pixel 0 in the low bits
    typedef rgb565_t [`FRAM_PIX_PER_BEAT-1:0] beat_t;

    // input port bundle
    typedef struct packed {
        logic    fsync;     // frame start pulse
        logic    en;        // pixel valid
        rgb888_t data;
    } pix_in_t;

    // packer fsm
    typedef enum logic {
        WAIT_SYNC,
        ACTIVE
    } pack_state_e;

endpackage

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fram_wr_tb \
    -f fram_wr_top.f -o fram_wr_sim \
    && ./obj_dir/fram_wr_sim | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verification/axi_mem_model.sv
`timescale 1ns/1ns
`include "fram_params.svh"

module axi_mem_model
(
    input  logic                            ddr_clk,
    input  logic                            arst_n,
    input  axi_pkg::axi_aw_t                aw,
    output logic                            awready,
    input  axi_pkg::axi_w_t                 w,
    output logic                            wready,
    input  int                              aw_wait,        // valid cycles before awready
    input  int                              w_stall_beat,   // beat held off, 8 for none
    input  int                              w_stall_len,    // cycles that beat waits
    input  logic                            w_block,        // wready low while set
    output int                              beat_idx,       // beat within current burst
    output int                              bursts_done     // bursts ended with last
);
    import axi_pkg::*;

    int aw_cnt;     // cycles aw has waited
    int w_cnt;      // cycles current beat has waited

    ////////////////////////////////////////
    // ready pattern
    ////////////////////////////////////////
    assign awready = (aw_cnt >= aw_wait);
    assign wready  = !w_block && ((beat_idx != w_stall_beat) || (w_cnt >= w_stall_len));

    ////////////////////////////////////////
    // capture
    ////////////////////////////////////////
    always_ff @(posedge ddr_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            aw_cnt      <= 0;
            w_cnt       <= 0;
            beat_idx    <= 0;
            bursts_done <= 0;
        end
        else
        begin
            if (aw.valid && !awready)
                aw_cnt <= aw_cnt + 1;
            else
                aw_cnt <= 0;                    // idle or accepted
            if (w.valid && !wready)
                w_cnt <= w_cnt + 1;
            else
                w_cnt <= 0;
            if (w.valid && wready)
            begin
                if (w.last)
                begin
                    beat_idx    <= 0;           // burst closed
                    bursts_done <= bursts_done + 1;
                end
                else
                    beat_idx <= beat_idx + 1;
            end
        end
    end

endmodule

//--- verification/fram_wr_tb.sv
`timescale 1ns/1ns
`include "fram_params.svh"

module fram_wr_tb;
    import video_pkg::*;
    import axi_pkg::*;

    localparam int H            = `FRAM_H_NUM;
    localparam int V            = `FRAM_V_NUM;
    localparam int PPB          = `FRAM_PIX_PER_BEAT;
    localparam int BEATS        = H / PPB;                  // beats per line burst
    localparam int PIX_W        = `FRAM_PIX_WIDTH;
    localparam int ADDR_W       = `FRAM_ADDR_WIDTH;
    localparam int SLOT_W       = $clog2(`FRAM_SLOT_COUNT);
    localparam int BLANK        = 16;                       // idle clocks after a line
    localparam int FRAME_CYCLES = V * (H + BLANK) + 1;      // sync clock plus lines
    localparam int CHECKED      = 5;                        // frames with full checking
    localparam int TIMEOUT      = 8 * FRAME_CYCLES + 1500;  // 7 frames, stalls, drain

    logic               ddr_clk;
    logic               arst_n;
    pix_in_t            pix_in;
    axi_aw_t            aw;
    logic               awready;
    axi_w_t             w;
    logic               wready;
    logic               frame_done;
    logic [SLOT_W-1:0]  frame_slot;
    logic               init_done;
    logic               overflow;

    int                 aw_wait;        // slave stall pattern
    int                 w_stall_beat;
    int                 w_stall_len;
    logic               w_block;
    int                 beat_idx;
    int                 bursts_done;

    logic               check_on;       // payload and frame checks armed
    logic               expect_idle;    // no burst allowed
    int                 cycle_cnt = 0;
    axi_aw_t            exp_aw;
    axi_w_t             exp_w;
    axi_aw_t            prev_aw;
    axi_w_t             prev_w;
    logic               aw_stalled;
    logic               w_stalled;
    logic               last_of_frame;
    logic               done_due;       // frame_done expected now
    logic               init_due;
    logic               ovf_prev;

    fram_wr_top fram_wr_top_i
    (
        .ddr_clk    (ddr_clk),
        .arst_n     (arst_n),
        .pix_in     (pix_in),
        .aw         (aw),
        .awready    (awready),
        .w          (w),
        .wready     (wready),
        .frame_done (frame_done),
        .frame_slot (frame_slot),
        .init_done  (init_done),
        .overflow   (overflow)
    );

    axi_mem_model mem_i
    (
        .ddr_clk        (ddr_clk),
        .arst_n         (arst_n),
        .aw             (aw),
        .awready        (awready),
        .w              (w),
        .wready         (wready),
        .aw_wait        (aw_wait),
        .w_stall_beat   (w_stall_beat),
        .w_stall_len    (w_stall_len),
        .w_block        (w_block),
        .beat_idx       (beat_idx),
        .bursts_done    (bursts_done)
    );

    initial ddr_clk = 1'b0;
    always #50 ddr_clk = ~ddr_clk;      // 100 ns period

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic rgb888_t pix_val(input int f, input int l, input int c);
        rgb888_t p;
        p.red   = 8'(c * 4 + f);
        p.green = 8'(l * 48 + c * 3);
        p.blue  = 8'(255 - c * 2 - f * 8);
        return p;
    endfunction

    // keep the top bits of each colour
    function automatic rgb565_t to565(input rgb888_t p);
        rgb565_t r;
        r.red   = p.red[7:3];
        r.green = p.green[7:2];
        r.blue  = p.blue[7:3];
        return r;
    endfunction

    // burst b is line b%V of frame b/V
    function automatic logic [PPB*PIX_W-1:0] exp_beat(input int b, input int k);
        logic [PPB*PIX_W-1:0] d;
        for (int j = 0; j < PPB; j++)
            d[j*PIX_W +: PIX_W] = to565(pix_val(b / V, b % V, k * PPB + j));
        return d;
    endfunction

    always_comb
    begin
        exp_aw.addr  = ADDR_W'(((bursts_done / V) % `FRAM_SLOT_COUNT)
                       * (1 << `FRAM_LINE_ADDR_WIDTH) + (bursts_done % V) * H * 2);
        exp_aw.len   = 4'd7;
        exp_aw.size  = 3'd4;            // 16 byte beats
        exp_aw.burst = INCR;
        exp_aw.valid = 1'b1;
        exp_w.data   = exp_beat(bursts_done, beat_idx);
        exp_w.strb   = '1;
        exp_w.last   = (beat_idx == BEATS - 1);
        exp_w.valid  = 1'b1;
    end

    assign last_of_frame = w.valid && wready && w.last && (bursts_done % V == V - 1);

    always_ff @(posedge ddr_clk)
    begin
        prev_aw    <= aw;
        prev_w     <= w;
        aw_stalled <= aw.valid && !awready;
        w_stalled  <= w.valid && !wready;
        done_due   <= last_of_frame;
        init_due   <= (bursts_done >= V);   // first frame landed
        ovf_prev   <= overflow;
    end

    ////////////////////////////////////////
    // error reporting
    ////////////////////////////////////////
    task automatic stop_with_fail();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] exp);
        $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        stop_with_fail();
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    a_reset_state: assert property (@(posedge ddr_clk) $rose(arst_n) |->
        {aw.valid, w.valid, init_done, frame_done, overflow, frame_slot} == '0)
        else report_mismatch("aw.valid,w.valid,init_done,frame_done,overflow,frame_slot",
            256'($sampled({aw.valid, w.valid, init_done, frame_done, overflow, frame_slot})),
            256'(0));

    a_idle: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        expect_idle |-> !aw.valid)
        else report_mismatch("aw.valid", 256'($sampled(aw.valid)), 256'(0));

    a_aw_hold: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        aw_stalled |-> aw == prev_aw)
        else report_mismatch("aw", 256'($sampled(aw)), 256'($sampled(prev_aw)));

    a_w_hold: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        w_stalled |-> w == prev_w)
        else report_mismatch("w", 256'($sampled(w)), 256'($sampled(prev_w)));

    a_aw_payload: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        check_on && aw.valid && awready |-> aw == exp_aw)
        else report_mismatch("aw", 256'($sampled(aw)), 256'($sampled(exp_aw)));

    a_w_payload: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        check_on && w.valid && wready |-> w == exp_w)
        else report_mismatch("w", 256'($sampled(w)), 256'($sampled(exp_w)));

    a_frame_done: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        check_on |-> frame_done == done_due)
        else report_mismatch("frame_done", 256'($sampled(frame_done)),
            256'($sampled(done_due)));

    a_slot: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        check_on |-> frame_slot == SLOT_W'((bursts_done / V) % `FRAM_SLOT_COUNT))
        else report_mismatch("frame_slot", 256'($sampled(frame_slot)),
            256'(($sampled(bursts_done) / V) % `FRAM_SLOT_COUNT));

    a_init: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        init_done == init_due)
        else report_mismatch("init_done", 256'($sampled(init_done)), 256'($sampled(init_due)));

    a_no_overflow: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        check_on |-> !overflow)
        else report_mismatch("overflow", 256'($sampled(overflow)), 256'(0));

    a_overflow_sticky: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        ovf_prev |-> overflow)
        else report_mismatch("overflow", 256'($sampled(overflow)), 256'(1));

    // hard stop if the pipeline stalls for good
    always @(posedge ddr_clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT)
        begin
            $display("timeout after %0d cycles, bursts did not drain", cycle_cnt);
            stop_with_fail();
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic idle_cycles(input int n);
        repeat (n) @(negedge ddr_clk);
    endtask

    task automatic send_frame(input int f, input logic with_sync);
        @(negedge ddr_clk);
        pix_in.fsync = with_sync;           // one clock sync slot
        pix_in.en    = 1'b0;
        pix_in.data  = '0;
        for (int l = 0; l < V; l++)
        begin
            for (int c = 0; c < H; c++)
            begin
                @(negedge ddr_clk);
                pix_in.fsync = 1'b0;
                pix_in.en    = 1'b1;
                pix_in.data  = pix_val(f, l, c);
            end
            @(negedge ddr_clk);
            pix_in.en = 1'b0;               // horizontal blank
            idle_cycles(BLANK - 1);
        end
    endtask

    task automatic wait_bursts(input int n);
        while (bursts_done < n)
            @(negedge ddr_clk);
    endtask

    initial
    begin
        pix_in       = '0;
        arst_n       = 1'b0;
        aw_wait      = 0;
        w_stall_beat = BEATS;               // no beat stalled
        w_stall_len  = 0;
        w_block      = 1'b0;
        check_on     = 1'b1;
        expect_idle  = 1'b0;
        repeat (4) @(negedge ddr_clk);
        arst_n = 1'b1;

        // pixels before any fsync
        expect_idle = 1'b1;
        send_frame(9, 1'b0);
        idle_cycles(20);
        expect_idle = 1'b0;

        // slave always ready
        for (int f = 0; f < 2; f++)
        begin
            send_frame(f, 1'b1);
            wait_bursts((f + 1) * V);
        end

        // short stalls on both channels, slot wraps in here
        aw_wait      = 6;
        w_stall_beat = 3;
        w_stall_len  = 40;
        for (int f = 2; f < CHECKED; f++)
        begin
            send_frame(f, 1'b1);
            wait_bursts((f + 1) * V);
        end
        idle_cycles(30);
        a_burst_count: assert (bursts_done == CHECKED * V)
            else report_mismatch("bursts_done", 256'(bursts_done), 256'(CHECKED * V));

        // wready held low across the frame
        check_on = 1'b0;
        w_block  = 1'b1;
        send_frame(CHECKED, 1'b1);
        a_overflow_set: assert (overflow)
            else report_mismatch("overflow", 256'(overflow), 256'(1));
        w_block = 1'b0;
        idle_cycles(60);

        $display("TEST PASS");
        $finish;
    end

endmodule
